//--- dv/int_div_iterative_tb.sv
// ----------------------------------------------------------------------
// iterative divider testbench
// random and directed divides, queued reference results, assertions
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module int_div_iterative_tb
  import div_pkg::*;
();

  localparam int NUM_TXN     = 200;
  localparam int TIMEOUT_CYC = NUM_TXN * 60;
  localparam int DIR_N       = 12;
  localparam int DRAIN_CYC   = 40;

  logic                clk;
  logic                reset;
  div_fn_e             req_fn;
  logic [DATA_W-1:0]   req_a;
  logic [DATA_W-1:0]   req_b;
  logic                req_val;
  logic                req_rdy;
  logic [RESULT_W-1:0] resp_result;
  logic                resp_val;
  logic                resp_rdy;

  // reference queue with one entry per accepted request
  logic [RESULT_W-1:0] exp_q[$];
  // registered copies for the assertions
  logic [RESULT_W-1:0] head_exp;
  int                  pend_cnt;
  int                  req_count;
  int                  resp_count;
  int                  cyc;
  // saturating count of edges since the last accept
  logic [7:0]          since_acc;
  logic [31:0]         lfsr;

  always #50 clk = ~clk;

  int_div_iterative u_int_div_iterative (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  // 32-bit fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[31]};
      lfsr = lfsr_next(lfsr);
    end
    return val;
  endfunction

  // reference result with remainder above quotient
  function automatic logic [RESULT_W-1:0] expected_result(input div_fn_e fn,
                                                         input logic [DATA_W-1:0] a,
                                                         input logic [DATA_W-1:0] b);
    logic signed [DATA_W-1:0] sa;
    logic signed [DATA_W-1:0] sb;
    logic signed [DATA_W-1:0] sq;
    logic signed [DATA_W-1:0] sr;
    sa = a;
    sb = b;
    if (b == '0) begin
      // divide by zero for both functions
      return {a, {DATA_W{1'b1}}};
    end
    if (fn == DIV_FN_SIGNED) begin
      // overflow case
      if (a == {1'b1, {(DATA_W-1){1'b0}}} && b == {DATA_W{1'b1}}) begin
        return {{DATA_W{1'b0}}, a};
      end
      // truncates toward zero and remainder follows dividend
      sq = sa / sb;
      sr = sa % sb;
      return {sr, sq};
    end
    return {a % b, a / b};
  endfunction

  task automatic report_fail(input string msg);
    $display("Fail %0t: %s", $time, msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic set_req(input div_fn_e fn, input logic [31:0] a, input logic [31:0] b);
    req_fn = fn;
    req_a  = a;
    req_b  = b;
  endtask

  // corner cases
  task automatic load_directed(input int idx);
    case (idx)
      0:  set_req(DIV_FN_UNSIGNED, 32'h1234_5678, 32'h0000_0000);
      1:  set_req(DIV_FN_SIGNED,   32'h8765_4321, 32'h0000_0000);
      2:  set_req(DIV_FN_SIGNED,   32'h8000_0000, 32'hffff_ffff);
      3:  set_req(DIV_FN_UNSIGNED, 32'h0000_0000, 32'h0000_0007);
      4:  set_req(DIV_FN_SIGNED,   32'h0000_0000, 32'hffff_fff9);
      5:  set_req(DIV_FN_UNSIGNED, 32'hdead_beef, 32'hdead_beef);
      6:  set_req(DIV_FN_SIGNED,   32'hffff_ff85, 32'hffff_ff85);
      // -7 and 7 over +-2 for the pairs with a negative operand
      7:  set_req(DIV_FN_SIGNED,   32'hffff_fff9, 32'h0000_0002);
      8:  set_req(DIV_FN_SIGNED,   32'h0000_0007, 32'hffff_fffe);
      9:  set_req(DIV_FN_SIGNED,   32'hffff_fff9, 32'hffff_fffe);
      10: set_req(DIV_FN_UNSIGNED, 32'hffff_ffff, 32'h0000_0003);
      default: set_req(DIV_FN_UNSIGNED, 32'h8000_0000, 32'hffff_ffff);
    endcase
  endtask

  task automatic load_random();
    logic [31:0] fn_bit;
    logic [31:0] neg;
    logic [31:0] sh;
    logic [31:0] a;
    logic [31:0] b;
    fn_bit = rand_bits(1);
    a      = rand_bits(32);
    // spread divisor magnitudes
    sh     = rand_bits(5);
    b      = rand_bits(32) >> sh;
    neg    = rand_bits(1);
    if (neg[0]) begin
      b = ~b + 1'b1;
    end
    set_req(fn_bit[0] ? DIV_FN_SIGNED : DIV_FN_UNSIGNED, a, b);
  endtask

  // ----------------------------------------------------------------------
  // monitor and reference queue
  // ----------------------------------------------------------------------

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (reset) begin
      since_acc  <= 8'hff;
      head_exp   <= '0;
      pend_cnt   <= 0;
      req_count  <= 0;
      resp_count <= 0;
    end else begin
      if (req_val && req_rdy) begin
        exp_q.push_back(expected_result(req_fn, req_a, req_b));
        req_count <= req_count + 1;
        since_acc <= 8'd1;
      end else if (since_acc != 8'hff) begin
        since_acc <= since_acc + 8'd1;
      end
      if (resp_val && resp_rdy) begin
        if (exp_q.size() > 0) begin
          void'(exp_q.pop_front());
        end
        resp_count <= resp_count + 1;
      end
      pend_cnt <= exp_q.size();
      head_exp <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end
  end

  // hang guard
  always @(posedge clk) begin
    if (cyc >= TIMEOUT_CYC) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Checks failed");
      $fatal(1);
    end
  end

  // ----------------------------------------------------------------------
  // assertions
  // ----------------------------------------------------------------------

  // idle and empty after reset
  a_reset_state: assert property (@(posedge clk)
    (cyc >= 2 && $past(reset)) |-> (req_rdy && !resp_val))
    else report_fail("req_rdy low or resp_val high after reset");

  // values from the reference model in request order
  a_result: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |-> (resp_result == head_exp))
    else report_fail($sformatf("result %h, expected %h", resp_result, head_exp));

  // no response without a pending request
  a_no_extra: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> (pend_cnt > 0))
    else report_fail("response with no request pending");

  // busy through CALC and the first DONE cycle
  a_busy: assert property (@(posedge clk) disable iff (reset)
    (since_acc <= 8'd33) |-> !req_rdy)
    else report_fail($sformatf("req_rdy high %0d edges after accept", since_acc));

  // hand-off at 33 edges or as soon as the fixup has room
  a_handoff: assert property (@(posedge clk) disable iff (reset)
    (!req_rdy && since_acc >= 8'd33 && (resp_rdy || !resp_val)) |=> (req_rdy && resp_val))
    else report_fail("result not handed to fixup when slot was free");

  // finished division waits in DONE
  a_wait: assert property (@(posedge clk) disable iff (reset)
    (!req_rdy && since_acc >= 8'd33 && resp_val && !resp_rdy) |=> !req_rdy)
    else report_fail("hand-off while fixup was full");

  // held response under back-pressure
  a_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)))
    else report_fail("response changed or dropped while stalled");

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  initial begin
    int          issued;
    int          gap_left;
    int          rdy_left;
    logic        stall;
    logic [31:0] r;
    clk        = 1'b0;
    reset      = 1'b1;
    req_fn     = DIV_FN_UNSIGNED;
    req_a      = '0;
    req_b      = '0;
    req_val    = 1'b0;
    resp_rdy   = 1'b0;
    lfsr       = 32'd39;
    issued     = 0;
    gap_left   = 0;
    rdy_left   = 0;
    stall      = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    while (resp_count < NUM_TXN) begin
      // some resp_rdy segments are long enough to stack two results
      if (rdy_left == 0) begin
        r     = rand_bits(3);
        stall = (r == 0);
        if (stall) begin
          rdy_left = 40 + int'(rand_bits(5));
        end else begin
          rdy_left = 8 + int'(rand_bits(6));
        end
      end
      rdy_left = rdy_left - 1;
      if (stall) begin
        resp_rdy = 1'b0;
      end else begin
        r        = rand_bits(3);
        resp_rdy = (r != 0);
      end
      // previous request taken on the last edge
      if (req_val && req_count == issued) begin
        req_val = 1'b0;
      end
      if (!req_val && issued < NUM_TXN) begin
        if (gap_left > 0) begin
          // gap cycles only count while the DUT is ready
          if (req_rdy) begin
            gap_left = gap_left - 1;
          end
        end else begin
          if (issued % 6 == 0 && issued / 6 < DIR_N) begin
            load_directed(issued / 6);
          end else begin
            load_random();
          end
          req_val  = 1'b1;
          issued   = issued + 1;
          gap_left = int'(rand_bits(2));
        end
      end
      @(posedge clk);
      #1;
    end
    // a duplicate would show up during the drain
    resp_rdy = 1'b1;
    repeat (DRAIN_CYC) @(posedge clk);
    #1;
    if (exp_q.size() != 0 || req_count != NUM_TXN) begin
      report_fail($sformatf("%0d results left over", exp_q.size()));
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- hw/div_core_if.sv
// ----------------------------------------------------------------------
// divider core interface
// links control, datapath and result fixup
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

interface div_core_if
  import div_pkg::*;
();

  // sequencing from control
  logic              load;
  logic              step;
  logic              capture;

  // unsigned magnitudes out of the datapath
  logic [DATA_W-1:0] quotient;
  logic [DATA_W-1:0] remainder;

  // sign correction flags
  logic              neg_quo;
  logic              neg_rem;

  // fixup can take a result this cycle
  logic              slot_free;

  modport ctrl  (output load, step, capture, input slot_free);
  modport dpath (input load, step, output quotient, remainder, neg_quo, neg_rem);
  modport fix   (input capture, quotient, remainder, neg_quo, neg_rem, output slot_free);

endinterface

`default_nettype wire

//--- hw/div_ctrl.sv
// ----------------------------------------------------------------------
// divider control
// FSM and step counter: load, shift-subtract steps, hand-off to fixup
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module div_ctrl
  import div_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       req_val,
  output logic       req_rdy,
  div_core_if.ctrl   core
);

  ctrl_state_e       state;
  ctrl_state_e       state_next;
  logic [CNT_W-1:0]  count;
  logic              last_step;
  logic              req_go;

  // ----------------------------------------------------------------------
  // handshake and sequencing outputs
  // ----------------------------------------------------------------------

  // only take a request when nothing is in the datapath
  assign req_rdy      = (state == IDLE);
  assign req_go       = req_rdy && req_val;

  // load on the accepting edge
  assign core.load    = req_go;

  // one shift-subtract per CALC cycle
  assign core.step    = (state == CALC);

  // hand result over only when fixup has room
  assign core.capture = (state == DONE) && core.slot_free;

  // final step of the division
  assign last_step    = (count == CNT_W'(ITER_CNT - 1));

  // ----------------------------------------------------------------------
  // next state
  // ----------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (req_go) begin
          state_next = CALC;
        end
      end
      CALC: begin
        if (last_step) begin
          state_next = DONE;
        end
      end
      DONE: begin
        // waits here under back-pressure
        if (core.slot_free) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  // ----------------------------------------------------------------------
  // state and counter registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      // restart count on accept, advance while stepping
      if (req_go) begin
        count <= '0;
      end else if (state == CALC) begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/div_dpath.sv
// ----------------------------------------------------------------------
// divider datapath
// operand magnitudes, sign flags and restoring shift-subtract registers
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module div_dpath
  import div_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  div_fn_e           req_fn,
  input  logic [DATA_W-1:0] req_a,
  input  logic [DATA_W-1:0] req_b,
  div_core_if.dpath         core
);

  // ----------------------------------------------------------------------
  // operand preparation
  // ----------------------------------------------------------------------

  logic              is_signed;
  logic              a_neg;
  logic              b_neg;
  logic              b_zero;
  logic [DATA_W-1:0] a_mag;
  logic [DATA_W-1:0] b_mag;

  assign is_signed = (req_fn == DIV_FN_SIGNED);

  // sign bits only count for signed requests
  assign a_neg     = is_signed && req_a[DATA_W-1];
  assign b_neg     = is_signed && req_b[DATA_W-1];
  assign b_zero    = (req_b == '0);

  // two's complement magnitudes
  // most negative value maps onto itself as unsigned
  assign a_mag     = a_neg ? (~req_a + 1'b1) : req_a;
  assign b_mag     = b_neg ? (~req_b + 1'b1) : req_b;

  // ----------------------------------------------------------------------
  // shift-subtract step
  // ----------------------------------------------------------------------

  logic [DATA_W-1:0] rem_reg;
  logic [DATA_W-1:0] quo_reg;
  logic [DATA_W-1:0] div_reg;
  logic [DATA_W:0]   rem_shift;
  logic [DATA_W:0]   diff;
  logic              diff_neg;

  // remainder and quotient shift left as one register pair
  // shifted partial remainder has one extra bit for the trial subtract
  assign rem_shift = {rem_reg, quo_reg[DATA_W-1]};

  // trial subtract
  assign diff      = rem_shift - {1'b0, div_reg};

  // top bit set means the divisor did not fit
  assign diff_neg  = diff[DATA_W];

  always_ff @(posedge clk) begin
    if (core.load) begin
      // dividend enters through the quotient register
      rem_reg <= '0;
      quo_reg <= a_mag;
      div_reg <= b_mag;
    end else if (core.step) begin
      if (diff_neg) begin
        // restore with quotient bit 0
        rem_reg <= rem_shift[DATA_W-1:0];
        quo_reg <= {quo_reg[DATA_W-2:0], 1'b0};
      end else begin
        // keep difference with quotient bit 1
        rem_reg <= diff[DATA_W-1:0];
        quo_reg <= {quo_reg[DATA_W-2:0], 1'b1};
      end
    end
  end

  // ----------------------------------------------------------------------
  // sign flags
  // ----------------------------------------------------------------------

  logic neg_quo_reg;
  logic neg_rem_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      neg_quo_reg <= 1'b0;
      neg_rem_reg <= 1'b0;
    end else if (core.load) begin
      // divide by zero keeps the all ones quotient
      neg_quo_reg <= (a_neg ^ b_neg) && !b_zero;
      // remainder follows the dividend
      neg_rem_reg <= a_neg;
    end
  end

  // ----------------------------------------------------------------------
  // outputs to fixup
  // ----------------------------------------------------------------------

  assign core.quotient  = quo_reg;
  assign core.remainder = rem_reg;
  assign core.neg_quo   = neg_quo_reg;
  assign core.neg_rem   = neg_rem_reg;

endmodule

`default_nettype wire

//--- hw/div_pkg.sv
// ----------------------------------------------------------------------
// iterative divider package
// widths, step count and the enums shared by the divider blocks
// ----------------------------------------------------------------------

`default_nettype none

package div_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------

  // operand width
  localparam int DATA_W = 32;

  // response packs remainder above quotient
  localparam int RESULT_W = 2 * DATA_W;

  // one quotient bit per step
  localparam int ITER_CNT = DATA_W;

  // step counter, wide enough for ITER_CNT
  localparam int CNT_W = 6;

  // ----------------------------------------------------------------------
  // types
  // ----------------------------------------------------------------------

  // request function
  typedef enum logic {
    DIV_FN_UNSIGNED = 1'b0,
    DIV_FN_SIGNED   = 1'b1
  } div_fn_e;

  // control FSM states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- hw/div_result_fix.sv
// ----------------------------------------------------------------------
// divider result fixup
// sign correction and the held response register
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module div_result_fix
  import div_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  output logic [RESULT_W-1:0] resp_result,
  output logic                resp_val,
  input  logic                resp_rdy,
  div_core_if.fix             core
);

  logic                full;
  logic                resp_go;
  logic [DATA_W-1:0]   quo_fixed;
  logic [DATA_W-1:0]   rem_fixed;
  logic [RESULT_W-1:0] result_reg;

  // ----------------------------------------------------------------------
  // sign correction
  // ----------------------------------------------------------------------

  assign quo_fixed = core.neg_quo ? (~core.quotient + 1'b1) : core.quotient;
  assign rem_fixed = core.neg_rem ? (~core.remainder + 1'b1) : core.remainder;

  // ----------------------------------------------------------------------
  // response handshake
  // ----------------------------------------------------------------------

  // response leaves on this edge
  assign resp_go        = full && resp_rdy;

  // empty, or draining this cycle
  assign core.slot_free = !full || resp_rdy;

  assign resp_val       = full;
  assign resp_result    = result_reg;

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------

  // payload, held until the response transfers
  always_ff @(posedge clk) begin
    if (core.capture) begin
      result_reg <= {rem_fixed, quo_fixed};
    end
  end

  // occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (core.capture) begin
      // new result replaces a departing one
      full <= 1'b1;
    end else if (resp_go) begin
      full <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hw/int_div_iterative.sv
// ----------------------------------------------------------------------
// iterative integer divider top
// 32-bit signed/unsigned divide with valid/ready request and response
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module int_div_iterative
  import div_pkg::*;
(
  input  logic                clk,
  input  logic                reset,

  // request side
  input  div_fn_e             req_fn,
  input  logic [DATA_W-1:0]   req_a,
  input  logic [DATA_W-1:0]   req_b,
  input  logic                req_val,
  output logic                req_rdy,

  // response side, remainder in upper half
  output logic [RESULT_W-1:0] resp_result,
  output logic                resp_val,
  input  logic                resp_rdy
);

  // control, datapath and fixup traffic
  div_core_if core ();

  // sequencing FSM
  div_ctrl u_ctrl (
    .clk     (clk),
    .reset   (reset),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .core    (core.ctrl)
  );

  // magnitude shift-subtract
  div_dpath u_dpath (
    .clk    (clk),
    .reset  (reset),
    .req_fn (req_fn),
    .req_a  (req_a),
    .req_b  (req_b),
    .core   (core.dpath)
  );

  // sign fix and response hold
  div_result_fix u_fix (
    .clk         (clk),
    .reset       (reset),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .core        (core.fix)
  );

endmodule

`default_nettype wire

//--- int_div_iterative.f
hw/div_pkg.sv
hw/div_core_if.sv
hw/div_ctrl.sv
hw/div_dpath.sv
hw/div_result_fix.sv
hw/int_div_iterative.sv
dv/int_div_iterative_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the iterative divider testbench with Verilator.
# The result is decided by the pass line in the simulation output.

set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module int_div_iterative_tb \
  -f int_div_iterative.f \
  -o int_div_iterative_sim

# a failing run stops with a nonzero status; the search below decides
out=$(./obj_dir/int_div_iterative_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
  echo "simulation PASSED"
  exit 0
else
  echo "simulation FAILED"
  exit 1
fi
